//--- bridge_defs.svh
/* Pin bridge widths and command byte layout
   Shared by the frame interface and the datapath blocks */

`ifndef BRIDGE_DEFS_SVH
`define BRIDGE_DEFS_SVH

// Wishbone side
`define BR_ADDR_W 32
`define BR_DATA_W 32

// Pin side
`define BR_PIN_W 8 // One byte per clock

// Bytes in one Wishbone word, and the width of an index into them
`define BR_NBYTES 4
`define BR_IDX_W 2

// Command byte layout
`define BR_CMD_WE_BIT 0 // Set for a write frame
`define BR_CMD_SEL_LSB 4 // Byte selects sit in bits 7..4

`endif

//--- bridge_pkg.sv
/* Pin bridge types
   Sequencer state encoding and the per-cycle pin phase */

package bridge_pkg;

  // Frame sequencer states
  typedef enum logic [2:0] {
    ST_IDLE  = 3'd0, // Waiting for cyc and stb
    ST_ADDR  = 3'd1, // Four address bytes
    ST_WDATA = 3'd2, // Four write-data bytes
    ST_CMD   = 3'd3, // Command byte
    ST_TURN  = 3'd4, // Pins change direction
    ST_RDATA = 3'd5, // Four read bytes from the device
    ST_ACK   = 3'd6  // Pin stage drains, ack follows
  } seq_state_t;

  // What the pins carry in a given cycle
  typedef enum logic [2:0] {
    PH_NONE  = 3'd0,
    PH_ADDR  = 3'd1,
    PH_WDATA = 3'd2,
    PH_CMD   = 3'd3,
    PH_RDATA = 3'd4
  } pin_phase_t;

endpackage

//--- frame_if.sv
/* Frame control bundle from the sequencer to the pin datapath
   Phase, byte index, word latch and read-complete strobe */

`timescale 1ns/1ps
`include "bridge_defs.svh"

interface frame_if;
  import bridge_pkg::*;

  pin_phase_t            phase;     // Pin phase for the coming byte
  logic [`BR_IDX_W-1:0] byte_idx;  // Byte lane within the phase
  logic                  latch;     // Capture the Wishbone word
  logic                  done_word; // Last read byte this cycle

  // Maps a sequencer state onto the phase the pins carry
  function automatic pin_phase_t phase_of(input seq_state_t s);
    case (s)
      ST_ADDR:  phase_of = PH_ADDR;
      ST_WDATA: phase_of = PH_WDATA;
      ST_CMD:   phase_of = PH_CMD;
      ST_RDATA: phase_of = PH_RDATA;
      default:  phase_of = PH_NONE; // IDLE, TURN and ACK leave the pins quiet
    endcase
  endfunction

  modport seq (
    output phase,
    output byte_idx,
    output latch,
    output done_word,
    import phase_of
  );

  modport dp (
    input phase,
    input byte_idx,
    input latch,
    input done_word
  );

endinterface

//--- frame_sequencer.sv
/* Frame sequencer
   Runs one pin frame per Wishbone cycle and returns a single-cycle ack */

`timescale 1ns/1ps

module frame_sequencer (
  input  logic clk,
  input  logic arst_n,
  input  logic cyc,
  input  logic stb,
  input  logic we,
  output logic ack,
  output logic cnt_load,
  output logic cnt_en,
  input  logic cnt_last,
  frame_if.seq fr
);
  import bridge_pkg::*;

  seq_state_t state;
  seq_state_t state_nxt;
  logic       start;

  // While ack is up the request on the bus is the one just finished
  assign start = cyc && stb && !ack;

  assign fr.phase = fr.phase_of(state);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state <= ST_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  always_comb begin
    state_nxt    = state;
    cnt_load     = 1'b0;
    cnt_en       = 1'b0;
    fr.latch     = 1'b0;
    fr.done_word = 1'b0;
    case (state)
      ST_IDLE: begin
        if (start) begin
          state_nxt = ST_ADDR;
          cnt_load  = 1'b1; // Address starts at byte 0
          fr.latch  = 1'b1;
        end
      end
      ST_ADDR: begin
        cnt_en = 1'b1;
        if (cnt_last) begin
          state_nxt = we ? ST_WDATA : ST_CMD;
          cnt_load  = 1'b1;
        end
      end
      ST_WDATA: begin
        cnt_en = 1'b1;
        if (cnt_last) begin
          state_nxt = ST_CMD;
          cnt_load  = 1'b1;
        end
      end
      ST_CMD: begin
        state_nxt = we ? ST_ACK : ST_TURN;
      end
      ST_TURN: begin
        state_nxt = ST_RDATA;
        cnt_load  = 1'b1; // Read lanes from 0
      end
      ST_RDATA: begin
        cnt_en = 1'b1;
        if (cnt_last) begin
          state_nxt    = ST_ACK;
          fr.done_word = 1'b1;
        end
      end
      ST_ACK: begin
        state_nxt = ST_IDLE;
      end
      default: begin
        state_nxt = ST_IDLE;
      end
    endcase
  end

  // The pin side runs one cycle behind the state, so ack is registered
  // to land after the last byte has left or arrived on the pins
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ack <= 1'b0;
    end else begin
      ack <= (state == ST_ACK) && cyc && stb;
    end
  end

  a_ack_single: assert property (
    @(posedge clk) disable iff (!arst_n)
    ack |=> !ack
  ) else $error("ack held for more than one cycle");

  a_ack_with_req: assert property (
    @(posedge clk) disable iff (!arst_n)
    ack |-> (cyc && stb)
  ) else $error("ack without cyc and stb");

endmodule

//--- byte_counter.sv
/* Byte index counter
   Paces the four bytes of each multi-byte frame phase */

`timescale 1ns/1ps
`include "bridge_defs.svh"

module byte_counter (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  load,
  input  logic                  en,
  output logic [`BR_IDX_W-1:0] count,
  output logic                  last
);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      count <= '0;
    end else if (load) begin
      count <= '0; // Load wins over en
    end else if (en) begin
      count <= count + 1'b1;
    end
  end

  // Final byte of the phase is being stepped past
  assign last = en && (count == (`BR_NBYTES - 1));

endmodule

//--- byte_serializer.sv
/* Pin byte serializer
   Holds the latched request and drives one registered byte per clock */

`timescale 1ns/1ps
`include "bridge_defs.svh"

module byte_serializer (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [`BR_ADDR_W-1:0] adr,
  input  logic [`BR_DATA_W-1:0] dat_w,
  input  logic [`BR_NBYTES-1:0] sel,
  input  logic                  we,
  frame_if.dp                   fr,
  output logic [`BR_PIN_W-1:0]  pin_out,
  output logic                  pin_valid,
  output logic                  pin_oe
);
  import bridge_pkg::*;

  logic [`BR_ADDR_W-1:0] adr_q;
  logic [`BR_DATA_W-1:0] dat_q;
  logic [`BR_PIN_W-1:0]  cmd_q;
  logic [`BR_PIN_W-1:0]  cmd_byte;
  logic [`BR_PIN_W-1:0]  byte_nxt;
  logic                  drive;

  always_comb begin
    cmd_byte = '0;
    cmd_byte[`BR_CMD_WE_BIT] = we;
    cmd_byte[`BR_CMD_SEL_LSB +: `BR_NBYTES] = sel;
  end

  always_ff @(posedge clk) begin
    if (fr.latch) begin
      adr_q <= adr;
      dat_q <= dat_w;
      cmd_q <= cmd_byte;
    end
  end

  always_comb begin
    case (fr.phase)
      PH_ADDR:  byte_nxt = adr_q[fr.byte_idx*`BR_PIN_W +: `BR_PIN_W]; // LSB first
      PH_WDATA: byte_nxt = dat_q[fr.byte_idx*`BR_PIN_W +: `BR_PIN_W];
      PH_CMD:   byte_nxt = cmd_q;
      default:  byte_nxt = '0;
    endcase
  end

  assign drive = fr.phase inside {PH_ADDR, PH_WDATA, PH_CMD};

  always_ff @(posedge clk) begin
    pin_out <= byte_nxt;
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pin_valid <= 1'b0;
      pin_oe    <= 1'b0;
    end else begin
      pin_valid <= drive;
      pin_oe    <= drive; // Released through TURN and RDATA
    end
  end

  // Pins are already released when read data starts, so a turnaround always precedes it
  a_no_drive_in_rdata: assert property (
    @(posedge clk) disable iff (!arst_n)
    (fr.phase == PH_RDATA) |-> !pin_oe ##1 !pin_oe
  ) else $error("pins driven while the device returns read data");

endmodule

//--- word_assembler.sv
/* Read word assembler
   Collects the four read bytes from the pins into the Wishbone read word */

`timescale 1ns/1ps
`include "bridge_defs.svh"

module word_assembler (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic [`BR_PIN_W-1:0]  pin_in,
  frame_if.dp                   fr,
  output logic [`BR_DATA_W-1:0] dat_r
);
  import bridge_pkg::*;

  logic                  rd_q;
  logic                  done_q;
  logic [`BR_IDX_W-1:0] idx_q;
  logic [`BR_DATA_W-1:0] word_q;
  logic [`BR_DATA_W-1:0] word_nxt;

  // Pins trail the sequencer by one cycle, so the controls are delayed to match
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rd_q   <= 1'b0;
      done_q <= 1'b0;
      idx_q  <= '0;
    end else begin
      rd_q   <= (fr.phase == PH_RDATA);
      done_q <= fr.done_word;
      idx_q  <= fr.byte_idx;
    end
  end

  always_comb begin
    word_nxt = word_q;
    word_nxt[idx_q*`BR_PIN_W +: `BR_PIN_W] = pin_in; // Lane named by byte index
  end

  always_ff @(posedge clk) begin
    if (rd_q) begin
      word_q <= word_nxt;
    end
    if (done_q) begin
      dat_r <= word_nxt; // Whole word updates at once, stable until next read
    end
  end

endmodule

//--- pin_bridge_top.sv
/* Wishbone to byte-serial pin bridge
   Sequencer, byte counter, serializer and read assembler */

`timescale 1ns/1ps
`include "bridge_defs.svh"

module pin_bridge_top (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  wb_cyc,
  input  logic                  wb_stb,
  input  logic                  wb_we,
  input  logic [`BR_ADDR_W-1:0] wb_adr,
  input  logic [`BR_DATA_W-1:0] wb_dat_w,
  input  logic [`BR_NBYTES-1:0] wb_sel,
  output logic                  wb_ack,
  output logic [`BR_DATA_W-1:0] wb_dat_r,
  output logic [`BR_PIN_W-1:0]  pin_out,
  output logic                  pin_valid,
  output logic                  pin_oe,
  input  logic [`BR_PIN_W-1:0]  pin_in
);

  logic cnt_load;
  logic cnt_en;
  logic cnt_last;

  frame_if fr ();

  frame_sequencer u_seq (
    .clk      (clk),
    .arst_n   (arst_n),
    .cyc      (wb_cyc),
    .stb      (wb_stb),
    .we       (wb_we),
    .ack      (wb_ack),
    .cnt_load (cnt_load),
    .cnt_en   (cnt_en),
    .cnt_last (cnt_last),
    .fr       (fr.seq)
  );

  byte_counter u_cnt (
    .clk    (clk),
    .arst_n (arst_n),
    .load   (cnt_load),
    .en     (cnt_en),
    .count  (fr.byte_idx), // Index goes straight onto the frame bundle
    .last   (cnt_last)
  );

  byte_serializer u_ser (
    .clk       (clk),
    .arst_n    (arst_n),
    .adr       (wb_adr),
    .dat_w     (wb_dat_w),
    .sel       (wb_sel),
    .we        (wb_we),
    .fr        (fr.dp),
    .pin_out   (pin_out),
    .pin_valid (pin_valid),
    .pin_oe    (pin_oe)
  );

  word_assembler u_asm (
    .clk    (clk),
    .arst_n (arst_n),
    .pin_in (pin_in),
    .fr     (fr.dp),
    .dat_r  (wb_dat_r)
  );

endmodule

//--- tb_pin_bridge.sv
/* Testbench for the Wishbone to pin bridge
   Wishbone master, pin-side device model and a table of bus cycles */

`timescale 1ns/1ps
`include "bridge_defs.svh"

module tb_pin_bridge;

  localparam int ACK_TIMEOUT = 50;
  localparam int MAX_ROWS    = 16;

  logic                  clk;
  logic                  arst_n;
  logic                  wb_cyc;
  logic                  wb_stb;
  logic                  wb_we;
  logic [`BR_ADDR_W-1:0] wb_adr;
  logic [`BR_DATA_W-1:0] wb_dat_w;
  logic [`BR_NBYTES-1:0] wb_sel;
  logic                  wb_ack;
  logic [`BR_DATA_W-1:0] wb_dat_r;
  logic [`BR_PIN_W-1:0]  pin_out;
  logic                  pin_valid;
  logic                  pin_oe;
  logic [`BR_PIN_W-1:0]  pin_in;

  // Stimulus table
  string                 row_name [0:MAX_ROWS-1];
  logic                  row_we   [0:MAX_ROWS-1];
  logic [`BR_ADDR_W-1:0] row_adr  [0:MAX_ROWS-1];
  logic [`BR_DATA_W-1:0] row_dat  [0:MAX_ROWS-1];
  logic [`BR_NBYTES-1:0] row_sel  [0:MAX_ROWS-1];
  logic                  row_hold [0:MAX_ROWS-1]; // Keep stb up into the next row
  logic [`BR_DATA_W-1:0] row_exp  [0:MAX_ROWS-1];
  int                    n_rows;

  string                 cur_test;
  logic [15:0]           lfsr;
  logic [`BR_DATA_W-1:0] shadow  [0:15];
  logic [`BR_DATA_W-1:0] dev_mem [0:15];

  // Device model state
  logic [`BR_PIN_W-1:0]  run_buf     [0:8];
  logic [`BR_PIN_W-1:0]  frame_bytes [0:8];
  int                    run_len;
  int                    run_start;
  int                    frame_len;
  int                    frame_start;
  int                    frame_cnt;
  int                    exp_frames;
  int                    neg_cnt;
  logic [`BR_DATA_W-1:0] rd_word;
  int                    rd_lane;
  int                    rd_left;
  logic                  dev_drive;

  pin_bridge_top DUT (
    .clk       (clk),
    .arst_n    (arst_n),
    .wb_cyc    (wb_cyc),
    .wb_stb    (wb_stb),
    .wb_we     (wb_we),
    .wb_adr    (wb_adr),
    .wb_dat_w  (wb_dat_w),
    .wb_sel    (wb_sel),
    .wb_ack    (wb_ack),
    .wb_dat_r  (wb_dat_r),
    .pin_out   (pin_out),
    .pin_valid (pin_valid),
    .pin_oe    (pin_oe),
    .pin_in    (pin_in)
  );

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic rand_word(output logic [`BR_DATA_W-1:0] w);
    int k;
    w = '0;
    for (k = 0; k < `BR_DATA_W; k++) begin
      w    = {w[`BR_DATA_W-2:0], lfsr[15]}; // One step per bit
      lfsr = lfsr_next(lfsr);
    end
  endtask

  function automatic logic [`BR_DATA_W-1:0] fill_word(input int idx);
    fill_word = 32'h9E37_79B9 ^ (idx * 32'h0101_0101) ^ (idx << 28);
  endfunction

  function automatic logic [`BR_DATA_W-1:0] merge_sel(
    input logic [`BR_DATA_W-1:0] old_w,
    input logic [`BR_DATA_W-1:0] new_w,
    input logic [`BR_NBYTES-1:0] sel
  );
    int k;
    merge_sel = old_w;
    for (k = 0; k < `BR_NBYTES; k++) begin
      if (sel[k]) begin
        merge_sel[k*`BR_PIN_W +: `BR_PIN_W] = new_w[k*`BR_PIN_W +: `BR_PIN_W];
      end
    end
  endfunction

  task automatic stop_run();
    $display("TEST RESULT: FAIL");
    $fatal(1, "Stopped at the first error");
  endtask

  task automatic word_eq(input string what, input logic [`BR_DATA_W-1:0] exp,
                         input logic [`BR_DATA_W-1:0] act);
    if (act !== exp) begin
      $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
      stop_run();
    end
  endtask

  task automatic byte_eq(input string what, input logic [`BR_PIN_W-1:0] exp,
                         input logic [`BR_PIN_W-1:0] act);
    if (act !== exp) begin
      $display("FAIL %s %s: expected %h, actual %h", cur_test, what, exp, act);
      stop_run();
    end
  endtask

  task automatic flag_eq(input string what, input logic exp, input logic act);
    if (act !== exp) begin
      $display("FAIL %s %s: expected %b, actual %b", cur_test, what, exp, act);
      stop_run();
    end
  endtask

  task automatic count_eq(input string what, input int exp, input int act);
    if (act != exp) begin
      $display("FAIL %s %s: expected %0d, actual %0d", cur_test, what, exp, act);
      stop_run();
    end
  endtask

  // A 9-byte run is a write frame, a 5-byte run a read frame
  task automatic end_frame();
    logic [`BR_ADDR_W-1:0] a;
    logic [`BR_PIN_W-1:0]  cmd;
    int                    k;
    if (run_len != 5 && run_len != 9) begin
      $display("%s: the pin device saw a frame of %0d bytes", cur_test, run_len);
      stop_run();
    end else begin
      a   = {run_buf[3], run_buf[2], run_buf[1], run_buf[0]};
      cmd = run_buf[run_len-1];
      for (k = 0; k < 9; k++) begin
        frame_bytes[k] = run_buf[k];
      end
      frame_len   = run_len;
      frame_start = run_start;
      frame_cnt++;
      if (run_len == 9) begin
        dev_mem[a[5:2]] = merge_sel(dev_mem[a[5:2]],
                                    {run_buf[7], run_buf[6], run_buf[5], run_buf[4]},
                                    cmd[`BR_CMD_SEL_LSB +: `BR_NBYTES]);
      end else begin
        rd_word = dev_mem[a[5:2]];
        rd_lane = 0;
        rd_left = `BR_NBYTES;
      end
    end
  endtask

  // Device samples the pins mid-cycle
  always @(negedge clk) begin
    neg_cnt++;
    if (arst_n) begin
      if (dev_drive) begin
        flag_eq("pin_oe while the device drives", 1'b0, pin_oe);
      end
      if (pin_valid) begin
        if (run_len == 0) begin
          run_start = neg_cnt;
        end
        if (run_len < 9) begin
          run_buf[run_len] = pin_out;
        end
        run_len++;
      end else if (run_len != 0) begin
        end_frame();
        run_len = 0;
      end
    end
  end

  // Read bytes go out after each edge, LSB first, once TURN has passed
  always @(posedge clk) begin
    #2;
    if (rd_left != 0) begin
      pin_in    = rd_word[rd_lane*`BR_PIN_W +: `BR_PIN_W];
      dev_drive = 1'b1;
      rd_lane++;
      rd_left--;
    end else begin
      pin_in    = '0;
      dev_drive = 1'b0;
    end
  end

  task automatic add_row(input string name, input logic we, input logic [`BR_ADDR_W-1:0] adr,
                         input logic [`BR_NBYTES-1:0] sel, input logic hold);
    row_name[n_rows] = name;
    row_we[n_rows]   = we;
    row_adr[n_rows]  = adr;
    row_sel[n_rows]  = sel;
    row_hold[n_rows] = hold;
    n_rows++;
  endtask

  task automatic build_table();
    int                    r;
    logic [`BR_DATA_W-1:0] w;
    n_rows = 0;
    add_row("wr_full",     1'b1, 32'h1234_5610, 4'b1111, 1'b0);
    add_row("rd_full",     1'b0, 32'h1234_5610, 4'b1111, 1'b0);
    add_row("rd_fill",     1'b0, 32'hA5C3_001C, 4'b1111, 1'b0);
    add_row("wr_sel_0001", 1'b1, 32'h0000_0020, 4'b0001, 1'b0);
    add_row("rd_sel_0001", 1'b0, 32'h0000_0020, 4'b1111, 1'b0);
    add_row("wr_sel_0110", 1'b1, 32'hFF00_0020, 4'b0110, 1'b0);
    add_row("rd_sel_0110", 1'b0, 32'h0000_0020, 4'b1111, 1'b0);
    add_row("wr_sel_1000", 1'b1, 32'h0BAD_F024, 4'b1000, 1'b0);
    add_row("rd_sel_1000", 1'b0, 32'h0BAD_F024, 4'b1111, 1'b0);
    add_row("b2b_wr_a",    1'b1, 32'h8000_0030, 4'b1111, 1'b1);
    add_row("b2b_rd_a",    1'b0, 32'h8000_0030, 4'b1111, 1'b1);
    add_row("b2b_wr_b",    1'b1, 32'h7FFF_FF3C, 4'b0011, 1'b1);
    add_row("b2b_rd_b",    1'b0, 32'h7FFF_FF3C, 4'b1111, 1'b0);
    for (r = 0; r < n_rows; r++) begin
      if (row_we[r]) begin
        rand_word(w);
        row_dat[r] = w;
        row_exp[r] = '0;
        shadow[row_adr[r][5:2]] = merge_sel(shadow[row_adr[r][5:2]], w, row_sel[r]);
      end else begin
        row_dat[r] = '0;
        row_exp[r] = shadow[row_adr[r][5:2]];
      end
    end
  endtask

  task automatic idle_check(input int n);
    int k;
    for (k = 0; k < n; k++) begin
      @(negedge clk);
      flag_eq("wb_ack while idle", 1'b0, wb_ack);
      flag_eq("pin_valid while idle", 1'b0, pin_valid);
      flag_eq("pin_oe while idle", 1'b0, pin_oe);
    end
    @(posedge clk);
    #2;
  endtask

  // Entered and left 2 ns after a rising edge
  task automatic run_cycle(input int r);
    int                   cycles;
    int                   c0;
    int                   k;
    int                   last_byte;
    logic                 got;
    logic                 drv_exp;
    logic [`BR_PIN_W-1:0] exp_cmd;
    cur_test  = row_name[r];
    last_byte = row_we[r] ? 9 : 5; // Frame cycle of the command byte
    wb_cyc    = 1'b1;
    wb_stb    = 1'b1;
    wb_we     = row_we[r];
    wb_adr    = row_adr[r];
    wb_dat_w  = row_dat[r];
    wb_sel    = row_sel[r];
    @(negedge clk);
    flag_eq("wb_ack before the frame", 1'b0, wb_ack); // Previous ack must be gone
    @(posedge clk);
    c0     = neg_cnt; // Edge that samples stb
    cycles = 0;
    got    = 1'b0;
    while (!got && cycles < ACK_TIMEOUT) begin
      @(negedge clk);
      cycles++; // Negedge n falls in frame cycle n-1
      drv_exp = (cycles >= 2) && (cycles <= last_byte + 1);
      flag_eq("pin_valid in frame", drv_exp, pin_valid);
      flag_eq("pin_oe in frame", drv_exp, pin_oe);
      got = wb_ack;
    end
    if (!got) begin
      $display("%s: wb_ack never came within %0d cycles", cur_test, ACK_TIMEOUT);
      stop_run();
    end else begin
      count_eq("ack latency", row_we[r] ? 10 : 11, cycles - 1);
      if (!row_we[r]) begin
        word_eq("read data", row_exp[r], wb_dat_r);
      end
      @(posedge clk);
      exp_frames++;
      count_eq("frames seen", exp_frames, frame_cnt);
      count_eq("pin frame length", row_we[r] ? 9 : 5, frame_len);
      count_eq("first address byte cycle", 1, frame_start - c0 - 1);
      for (k = 0; k < `BR_NBYTES; k++) begin
        byte_eq("address byte", row_adr[r][k*`BR_PIN_W +: `BR_PIN_W], frame_bytes[k]);
        if (row_we[r]) begin
          byte_eq("write byte", row_dat[r][k*`BR_PIN_W +: `BR_PIN_W], frame_bytes[4+k]);
        end
      end
      exp_cmd = '0;
      exp_cmd[`BR_CMD_WE_BIT] = row_we[r];
      exp_cmd[`BR_CMD_SEL_LSB +: `BR_NBYTES] = row_sel[r];
      byte_eq("command byte", exp_cmd, frame_bytes[frame_len-1]);
      #2;
      if (!row_hold[r]) begin
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
      end
    end
  endtask

  initial begin
    int i;
    arst_n     = 1'b0;
    wb_cyc     = 1'b0;
    wb_stb     = 1'b0;
    wb_we      = 1'b0;
    wb_adr     = '0;
    wb_dat_w   = '0;
    wb_sel     = '0;
    pin_in     = '0;
    lfsr       = 16'd94;
    run_len    = 0;
    rd_left    = 0;
    rd_lane    = 0;
    dev_drive  = 1'b0;
    neg_cnt    = 0;
    frame_cnt  = 0;
    exp_frames = 0;
    cur_test   = "reset";
    for (i = 0; i < 16; i++) begin
      dev_mem[i] = fill_word(i);
      shadow[i]  = fill_word(i);
    end
    build_table();
    repeat (5) @(posedge clk);
    #2;
    arst_n = 1'b1;
    idle_check(4);
    for (i = 0; i < n_rows; i++) begin
      run_cycle(i);
      if (!row_hold[i]) begin
        idle_check(2);
      end
    end
    $display("TEST RESULT: PASS");
    $finish;
  end

endmodule

//--- sources.f
+incdir+.
bridge_pkg.sv
frame_if.sv
frame_sequencer.sv
byte_counter.sv
byte_serializer.sv
word_assembler.sv
pin_bridge_top.sv
tb_pin_bridge.sv

//--- Bender.yml
package:
  name: pin_bridge

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - bridge_pkg.sv
      - frame_if.sv
      - frame_sequencer.sv
      - byte_counter.sv
      - byte_serializer.sv
      - word_assembler.sv
      - pin_bridge_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_pin_bridge.sv
